// File: telemetry_pkg.sv
package telemetry_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int UART_DATA_BITS = 8;
    localparam int POS_W          = 32;
    localparam int YAW_W          = 16;
    localparam int ANGLE_W        = 12;
    localparam int BAUD_DIV_W     = 14;
    localparam int BYTE_IDX_W     = 5;

    typedef logic [UART_DATA_BITS-1:0] byte_t;
    typedef logic signed [POS_W-1:0]   pos_t;
    typedef logic [YAW_W-1:0]          yaw_t;
    typedef logic [7:0]                sensors_t;
    typedef logic [ANGLE_W-1:0]        angle_t;
    typedef logic [1:0]                mode_t;
    typedef logic [2:0]                motor_t;
    typedef logic [BAUD_DIV_W-1:0]     baud_div_t;   // Clocks per UART bit.
    typedef logic [BYTE_IDX_W-1:0]     byte_idx_t;
    typedef logic [1:0]                gap_cnt_t;

    // ----------------------------------------
    // Frame layout
    // ----------------------------------------
    localparam int    FRAME_LEN = 23;
    localparam byte_t SYNC_BYTE = 8'h99;

    // First byte of each field within the frame.
    localparam byte_idx_t IDX_SYNC     = 5'd0;
    localparam byte_idx_t IDX_POS_X    = 5'd1;
    localparam byte_idx_t IDX_POS_Y    = 5'd5;
    localparam byte_idx_t IDX_YAW      = 5'd9;
    localparam byte_idx_t IDX_SENSORS  = 5'd11;
    localparam byte_idx_t IDX_ANGLE_LO = 5'd12;
    localparam byte_idx_t IDX_FLAGS    = 5'd13;   // Reached, motor, angle high nibble.
    localparam byte_idx_t IDX_MODE     = 5'd14;   // Mode and upper divider bits.
    localparam byte_idx_t IDX_TGT_X    = 5'd15;
    localparam byte_idx_t IDX_TGT_Y    = 5'd19;

    // ----------------------------------------
    // Timing
    // ----------------------------------------
    // Idle clocks with tx_en high between a done pulse and the next byte.
    localparam int GAP_CYCLES = 2;

endpackage

// File: telemetry_field_mux.sv
`timescale 1ns/1ps

module telemetry_field_mux
    import telemetry_pkg::*;
(
    input  byte_idx_t byte_index,
    input  pos_t      current_x,
    input  pos_t      current_y,
    input  pos_t      target_x,
    input  pos_t      target_y,
    input  yaw_t      yaw,
    input  sensors_t  sensors,
    input  angle_t    angle,
    input  logic      target_reached,
    input  motor_t    motor,
    input  mode_t     mode,
    input  baud_div_t clks_per_bit,
    output byte_t     frame_byte
);

    // Little-endian byte of a 32-bit coordinate.
    function automatic byte_t pos_byte(pos_t value, byte_idx_t offset);
        return value[offset[1:0]*8 +: 8];
    endfunction

    // Fields are ordered by start index, so the highest matching start wins.
    always_comb begin
        if (byte_index == IDX_SYNC || byte_index >= FRAME_LEN) begin
            frame_byte = SYNC_BYTE;
        end else if (byte_index >= IDX_TGT_Y) begin
            frame_byte = pos_byte(target_y, byte_idx_t'(byte_index - IDX_TGT_Y));
        end else if (byte_index >= IDX_TGT_X) begin
            frame_byte = pos_byte(target_x, byte_idx_t'(byte_index - IDX_TGT_X));
        end else if (byte_index >= IDX_MODE) begin
            frame_byte = {mode, clks_per_bit[13:8]};
        end else if (byte_index >= IDX_FLAGS) begin
            frame_byte = {target_reached, motor, angle[11:8]};
        end else if (byte_index >= IDX_ANGLE_LO) begin
            frame_byte = angle[7:0];
        end else if (byte_index >= IDX_SENSORS) begin
            frame_byte = sensors;
        end else if (byte_index >= IDX_YAW) begin
            frame_byte = (byte_index == IDX_YAW) ? yaw[7:0] : yaw[15:8];
        end else if (byte_index >= IDX_POS_Y) begin
            frame_byte = pos_byte(current_y, byte_idx_t'(byte_index - IDX_POS_Y));
        end else begin
            frame_byte = pos_byte(current_x, byte_idx_t'(byte_index - IDX_POS_X));
        end
    end

    // The sequencer wraps before FRAME_LEN, so a larger index means its counter broke.
    always_comb begin
        a_index_range: assert (byte_index < FRAME_LEN)
            else $error("byte_index %0d is outside the frame", byte_index);
    end

endmodule

// File: telemetry_sequencer.sv
`timescale 1ns/1ps

module telemetry_sequencer
    import telemetry_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      tx_en,
    input  logic      done,
    output byte_idx_t byte_index,
    output logic      byte_start
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_DONE,
        SEQ_GAP
    } seq_state_t;

    seq_state_t state;
    gap_cnt_t   gap_cnt;
    logic       last_gap;
    logic       last_byte;
    logic       outstanding;

    assign last_gap  = (gap_cnt == gap_cnt_t'(GAP_CYCLES - 1));
    assign last_byte = (byte_index == byte_idx_t'(FRAME_LEN - 1));

    // ----------------------------------------
    // Frame stepping
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            byte_index <= '0;
            gap_cnt    <= '0;
            byte_start <= 1'b0;
        end else begin
            byte_start <= 1'b0;                 // Single-clock strobe by default.
            case (state)
                SEQ_IDLE: begin
                    if (tx_en) begin
                        byte_start <= 1'b1;
                        state      <= SEQ_WAIT_DONE;
                    end
                end
                SEQ_WAIT_DONE: begin
                    // A byte in flight always completes, whatever tx_en does.
                    if (done) begin
                        gap_cnt    <= '0;
                        byte_index <= last_byte ? '0 : byte_index + 1'b1;
                        state      <= SEQ_GAP;
                    end
                end
                SEQ_GAP: begin
                    if (tx_en) begin                // The gap freezes while disabled.
                        if (last_gap) begin
                            byte_start <= 1'b1;
                            state      <= SEQ_WAIT_DONE;
                        end else begin
                            gap_cnt <= gap_cnt + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Tracks a byte from its start strobe to the serializer's done pulse.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (byte_start) begin
            outstanding <= 1'b1;
        end else if (done) begin
            outstanding <= 1'b0;
        end
    end

    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        byte_start |=> !byte_start);

    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        byte_start |-> !outstanding);

endmodule

// File: uart_serializer.sv
`timescale 1ns/1ps

module uart_serializer
    import telemetry_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      byte_start,
    input  byte_t     byte_data,
    input  baud_div_t clks_per_bit,
    output logic      serial_out,
    output logic      busy,
    output logic      done
);

    logic [UART_DATA_BITS:0] shift_q;     // Data bits with the stop bit on top.
    baud_div_t               period_q;
    baud_div_t               period_cnt;
    logic [3:0]              bit_cnt;
    logic                    accept;
    logic                    bit_end;
    logic                    last_bit;

    assign accept   = byte_start && !busy;
    assign bit_end  = busy && (period_cnt == baud_div_t'(period_q - 1'b1));
    assign last_bit = (bit_cnt == 4'(UART_DATA_BITS + 1));

    // ----------------------------------------
    // Payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q  <= {1'b1, byte_data};
            period_q <= clks_per_bit;           // Held for the whole character.
        end else if (bit_end) begin
            shift_q  <= {1'b1, shift_q[UART_DATA_BITS:1]};
        end
    end

    // ----------------------------------------
    // Bit timing and line control
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            serial_out <= 1'b1;
            busy       <= 1'b0;
            done       <= 1'b0;
            period_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                serial_out <= 1'b0;             // Start bit.
                busy       <= 1'b1;
                period_cnt <= '0;
                bit_cnt    <= '0;
            end else if (busy) begin
                if (bit_end) begin
                    period_cnt <= '0;
                    if (last_bit) begin
                        // End of the stop bit. The line is already high.
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        serial_out <= shift_q[0];
                        bit_cnt    <= bit_cnt + 1'b1;
                    end
                end else begin
                    period_cnt <= period_cnt + 1'b1;
                end
            end
        end
    end

    // A period of one clock would make bit_end fire on the capture cycle's divider.
    a_min_period: assert property (@(posedge clk) disable iff (reset)
        byte_start |-> clks_per_bit >= 2);

endmodule

// File: telemetry_tx.sv
`timescale 1ns/1ps

module telemetry_tx
    import telemetry_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      tx_en,
    input  pos_t      current_x,
    input  pos_t      current_y,
    input  pos_t      target_x,
    input  pos_t      target_y,
    input  yaw_t      yaw,
    input  sensors_t  sensors,
    input  angle_t    angle,
    input  logic      target_reached,
    input  motor_t    motor,
    input  mode_t     mode,
    input  baud_div_t clks_per_bit,
    output logic      serial_out
);

    byte_idx_t byte_index;
    byte_t     frame_byte;
    logic      byte_start;
    logic      busy;
    logic      done;

    // Field decode. The byte is taken from the live inputs when it starts.
    telemetry_field_mux field_mux0 (
        .byte_index     (byte_index),
        .current_x      (current_x),
        .current_y      (current_y),
        .target_x       (target_x),
        .target_y       (target_y),
        .yaw            (yaw),
        .sensors        (sensors),
        .angle          (angle),
        .target_reached (target_reached),
        .motor          (motor),
        .mode           (mode),
        .clks_per_bit   (clks_per_bit),
        .frame_byte     (frame_byte)
    );

    telemetry_sequencer sequencer0 (
        .clk        (clk),
        .reset      (reset),
        .tx_en      (tx_en),
        .done       (done),
        .byte_index (byte_index),
        .byte_start (byte_start)
    );

    uart_serializer serializer0 (
        .clk          (clk),
        .reset        (reset),
        .byte_start   (byte_start),
        .byte_data    (frame_byte),
        .clks_per_bit (clks_per_bit),
        .serial_out   (serial_out),
        .busy         (busy),
        .done         (done)
    );

    // The serializer drops a start that arrives while it is sending.
    a_start_when_free: assert property (@(posedge clk) disable iff (reset)
        byte_start |-> !busy);

endmodule

// File: tb_telemetry_checks.svh
`ifndef TB_TELEMETRY_CHECKS_SVH
`define TB_TELEMETRY_CHECKS_SVH

// Whole frame packed with index 0 in the lowest byte, so multi-byte fields come out
// little-endian.
function automatic byte_t frame_byte_ref(byte_idx_t idx, pos_t cx, pos_t cy, yaw_t yw,
                                         sensors_t sn, angle_t an, logic reached,
                                         motor_t mt, mode_t md, baud_div_t div,
                                         pos_t tx, pos_t ty);
    logic [FRAME_LEN*8-1:0] frame;
    frame = {ty, tx, md, div[13:8], reached, mt, an[11:8], an[7:0],
             sn, yw, cy, cx, SYNC_BYTE};
    return byte_t'(frame >> (8 * idx));
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11. One step per bit taken.
function automatic logic [31:0] take_bits(int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

task automatic check_byte(string name, byte_t expected, byte_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected 0x%02h actual 0x%02h", name, expected, actual);
        err_cnt++;
    end
endtask

task automatic check_frame_len(byte_idx_t expected, byte_idx_t actual);
    if (actual !== expected) begin
        $display("ERR frame_len expected 0x%02h actual 0x%02h", expected, actual);
        err_cnt++;
    end
endtask

task automatic check_line(string name, logic expected, logic actual);
    if (actual !== expected) begin
        $display("ERR %s expected 0x%01h actual 0x%01h", name, expected, actual);
        err_cnt++;
    end
endtask

`endif

// File: tb_telemetry_tx.sv
`timescale 1ns/1ps

module tb_telemetry_tx
    import telemetry_pkg::*;
();

    logic      clk;
    logic      reset;
    logic      tx_en;
    pos_t      current_x;
    pos_t      current_y;
    pos_t      target_x;
    pos_t      target_y;
    yaw_t      yaw;
    sensors_t  sensors;
    angle_t    angle;
    logic      target_reached;
    motor_t    motor;
    mode_t     mode;
    baud_div_t clks_per_bit;
    logic      serial_out;

    byte_t       rx_q[$];
    logic [15:0] lfsr_state = 16'd12;
    int          err_cnt    = 0;
    int          n_rx       = 0;
    int          n_checked  = 0;
    logic        timed_out  = 1'b0;
    byte_t       mode_byte  = '0;           // Last byte received at IDX_MODE.

    `include "tb_telemetry_checks.svh"

    telemetry_tx dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Serial receiver and comparison
    // ----------------------------------------
    initial begin : receiver
        int    period;
        byte_t data;
        forever begin
            @(posedge clk);
            if (!reset && serial_out == 1'b0) begin
                period = int'(clks_per_bit);
                repeat (period / 2) @(posedge clk);     // Middle of the start bit.
                data = '0;
                for (int i = 0; i < UART_DATA_BITS; i++) begin
                    repeat (period) @(posedge clk);
                    data = {serial_out, data[7:1]};    // LSB arrives first.
                end
                repeat (period) @(posedge clk);
                if (serial_out !== 1'b1) begin
                    $display("Stop bit of received byte %0d was low", n_rx);
                    err_cnt++;
                end
                rx_q.push_back(data);
                n_rx++;
            end
        end
    end

    always @(posedge clk) begin : compare
        byte_t     got;
        byte_idx_t exp_idx;
        byte_idx_t frame_cnt;
        logic      seen_sync;
        if (reset) begin
            exp_idx   = '0;
            frame_cnt = '0;
            seen_sync = 1'b0;
        end else if (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            // A frame is counted from one sync byte to the next. A data byte of 0x99
            // comes too early in the frame to be taken for a sync.
            if (got == SYNC_BYTE && (!seen_sync || frame_cnt >= byte_idx_t'(FRAME_LEN))) begin
                if (seen_sync) check_frame_len(byte_idx_t'(FRAME_LEN), frame_cnt);
                seen_sync = 1'b1;
                frame_cnt = '0;
            end
            check_byte($sformatf("serial_out byte %0d", exp_idx),
                       frame_byte_ref(exp_idx, current_x, current_y, yaw, sensors, angle,
                                      target_reached, motor, mode, clks_per_bit,
                                      target_x, target_y), got);
            if (exp_idx == IDX_MODE) mode_byte = got;
            if (frame_cnt != '1) frame_cnt = frame_cnt + 1'b1;  // Saturates on a long frame.
            exp_idx   = (exp_idx == byte_idx_t'(FRAME_LEN - 1)) ? '0 : exp_idx + 1'b1;
            n_checked++;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic randomize_fields;
        current_x      <= pos_t'(take_bits(32));
        current_y      <= pos_t'(take_bits(32));
        target_x       <= pos_t'(take_bits(32));
        target_y       <= pos_t'(take_bits(32));
        yaw            <= yaw_t'(take_bits(16));
        sensors        <= sensors_t'(take_bits(8));
        angle          <= angle_t'(take_bits(12));
        target_reached <= 1'(take_bits(1));
        motor          <= motor_t'(take_bits(3));
        mode           <= mode_t'(take_bits(2));
    endtask

    function automatic int frame_limit(baud_div_t div);
        return FRAME_LEN * (10 * int'(div) + 8) + 100;
    endfunction

    task automatic wait_checked(int target, int limit);
        int cycles;
        cycles = 0;
        while (n_checked < target && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timed out waiting for byte %0d, %0d bytes arrived", target, n_checked);
                timed_out = 1'b1;
                err_cnt++;
            end
        end
    endtask

    task automatic report_case(int num, string name, int errs_before);
        if (err_cnt == errs_before) begin
            $display("case %0d %s: ok", num, name);
        end else begin
            $display("case %0d %s: %0d errors", num, name, err_cnt - errs_before);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : tests
        int errs_before;
        int base;
        int rx_before;
        reset        = 1'b1;
        tx_en        = 1'b0;
        clks_per_bit = 14'd8;
        {current_x, current_y, target_x, target_y, yaw, sensors} = '0;
        {angle, target_reached, motor, mode} = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        errs_before = err_cnt;
        for (int i = 0; i < 200; i++) begin
            @(posedge clk);
            check_line("serial_out", 1'b1, serial_out);
        end
        if (n_rx != 0) begin
            $display("A byte was received while tx_en was low");
            err_cnt++;
        end
        report_case(1, "idle line while disabled", errs_before);

        errs_before = err_cnt;
        randomize_fields();
        tx_en <= 1'b1;
        wait_checked(FRAME_LEN, frame_limit(clks_per_bit));
        report_case(2, "first frame", errs_before);

        // New fields land right after byte 22, before byte 1 of the next frame loads.
        errs_before = err_cnt;
        base        = n_checked;
        for (int f = 1; f <= 3; f++) begin
            randomize_fields();
            wait_checked(base + f * FRAME_LEN, frame_limit(clks_per_bit));
        end
        report_case(3, "back-to-back frames", errs_before);

        errs_before = err_cnt;
        base        = n_checked;
        current_x <= -pos_t'(take_bits(20)) - 1;
        current_y <= -pos_t'(take_bits(20)) - 1;
        target_x  <= -pos_t'(take_bits(20)) - 1;
        target_y  <= -pos_t'(take_bits(20)) - 1;
        wait_checked(base + FRAME_LEN, frame_limit(clks_per_bit));
        report_case(4, "negative positions", errs_before);

        errs_before = err_cnt;
        base        = n_checked;
        wait_checked(base + 11, frame_limit(clks_per_bit));
        repeat (16) @(posedge clk);                 // Byte 11 is on the line by now.
        tx_en    <= 1'b0;
        rx_before = n_rx;
        for (int i = 0; i < 300; i++) begin
            @(posedge clk);
            if (i >= 150) check_line("serial_out", 1'b1, serial_out);
        end
        if (n_rx != rx_before + 1) begin
            $display("Expected one byte to finish during the pause, %0d did", n_rx - rx_before);
            err_cnt++;
        end
        tx_en <= 1'b1;
        wait_checked(base + 2 * FRAME_LEN, 2 * frame_limit(clks_per_bit));
        report_case(5, "pause mid-frame", errs_before);

        // The divider only changes while the line is idle at a frame boundary.
        errs_before = err_cnt;
        base        = n_checked;
        tx_en      <= 1'b0;
        repeat (12) @(posedge clk);
        clks_per_bit <= 14'd259;
        randomize_fields();
        @(posedge clk);
        tx_en <= 1'b1;
        wait_checked(base + FRAME_LEN, frame_limit(14'd259));
        check_byte("serial_out byte 14 divider bits", 8'h01, {2'b00, mode_byte[5:0]});
        report_case(6, "second bit period", errs_before);

        tx_en <= 1'b0;
        repeat (20) @(posedge clk);
        if (rx_q.size() != 0) begin
            $display("%0d received bytes were never compared", rx_q.size());
            err_cnt++;
        end
        $display("summary: %0d bytes checked, %0d errors", n_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
telemetry_pkg.sv
telemetry_field_mux.sv
telemetry_sequencer.sv
uart_serializer.sv
telemetry_tx.sv
tb_telemetry_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_telemetry_tx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
